// ==== common/soc_io_defs.svh ====
`ifndef SOC_IO_DEFS_SVH
`define SOC_IO_DEFS_SVH

// Build-time defaults for the I/O register block

// Default system clock in Hz
`define SOC_IO_CLOCK_FREQ 100000000

// Default UART line rate in bits per second
`define SOC_IO_BAUD_RATE 115200

// Only this many low address bits take part in register decode,
// so the block answers at any base the interconnect places it at
`define SOC_IO_DECODE_W 8

// Width of the bus data path
// Only byte lane 0 carries register data
`define SOC_IO_DATA_W 32

`endif

// ==== common/soc_io_pkg.sv ====
`default_nettype none

`include "soc_io_defs.svh"

package soc_io_pkg;

  // One bus write, valid in the cycle where wen is high
  // No handshake, the register block always accepts it
  typedef struct packed {
    logic                      wen;
    logic [31:0]               addr;
    logic [`SOC_IO_DATA_W-1:0] data;
    logic [3:0]                strb;
  } io_wr_req_t;

  // One bus read, valid in the cycle where ren is high
  // Data comes back registered on the following cycle
  typedef struct packed {
    logic        ren;
    logic [31:0] addr;
  } io_rd_req_t;

  // Register map, offsets within the decoded window
  typedef enum logic [`SOC_IO_DECODE_W-1:0] {
    // Transmit data, byte lane 0, write only
    REG_UART_TX     = 8'h00,
    // Bit 0 is transmitter ready
    REG_UART_STATUS = 8'h04,
    // Bit 0 drives the LED
    REG_LED         = 8'h08,
    // Byte lane 0 drives the GPIO outputs
    REG_GPIO        = 8'h0C
  } io_reg_off_e;

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/soc_io_pkg.sv
uart/uart_tx.sv
io_reg/io_reg_file.sv
src/soc_io_top.sv
verification/soc_io_chk.sv
verification/soc_io_tb.sv

// ==== io_reg/io_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_defs.svh"

// Register file for the I/O window
// Writes and reads complete in one cycle, there is no stall
module io_reg_file
  import soc_io_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire io_wr_req_t            wr_req,
  input  wire io_rd_req_t            rd_req,
  input  wire                        tx_ready,
  output logic [`SOC_IO_DATA_W-1:0]  rdata,
  output logic                       led,
  output logic [7:0]                 gpio,
  output logic                       tx_start,
  output logic [7:0]                 tx_byte
);

  logic [`SOC_IO_DECODE_W-1:0] wr_off;
  logic [`SOC_IO_DECODE_W-1:0] rd_off;

  // Only byte lane 0 holds register data
  logic                        wr_lane0;

  logic                        wr_led;
  logic                        wr_gpio;
  logic                        wr_tx;
  logic                        tx_launch;

  logic [`SOC_IO_DATA_W-1:0]   rd_val;

  // Upper address bits are ignored
  assign wr_off   = wr_req.addr[`SOC_IO_DECODE_W-1:0];
  assign rd_off   = rd_req.addr[`SOC_IO_DECODE_W-1:0];
  assign wr_lane0 = wr_req.wen && wr_req.strb[0];

  // Write decode, unmapped offsets select nothing
  always_comb begin
    wr_led  = 1'b0;
    wr_gpio = 1'b0;
    wr_tx   = 1'b0;
    if (wr_lane0) begin
      case (wr_off)
        REG_UART_TX: wr_tx   = 1'b1;
        REG_LED:     wr_led  = 1'b1;
        REG_GPIO:    wr_gpio = 1'b1;
        default: begin
        end
      endcase
    end
  end

  // A pending start is still in flight while tx_start is high, because
  // tx_ready only falls on the edge that consumes it.  Without the mask a
  // second write in that cycle would restart the frame
  assign tx_launch = wr_tx && tx_ready && !tx_start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led  <= 1'b0;
      gpio <= 8'h00;
    end else begin
      if (wr_led) begin
        led <= wr_req.data[0];
      end
      if (wr_gpio) begin
        gpio <= wr_req.data[7:0];
      end
    end
  end

  // One-cycle start pulse toward the transmitter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= tx_launch;
    end
  end

  // Byte is only sampled by the transmitter with tx_start
  always_ff @(posedge clk) begin
    if (tx_launch) begin
      tx_byte <= wr_req.data[7:0];
    end
  end

  // Read mux, transmit data reads as zero
  always_comb begin
    rd_val = '0;
    case (rd_off)
      REG_UART_STATUS: rd_val[0]   = tx_ready;
      REG_LED:         rd_val[0]   = led;
      REG_GPIO:        rd_val[7:0] = gpio;
      default: begin
      end
    endcase
  end

  // rdata holds until the next read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (rd_req.ren) begin
      rdata <= rd_val;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the I/O block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vsoc_io_tb

# Compile testbench, checker and RTL
verilator --binary --timing --assert \
  --top-module soc_io_tb \
  -f filelist.f \
  -o Vsoc_io_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

if [ ! -x "$BIN" ]; then
  echo "Simulation binary $BIN not found"
  exit 1
fi

# Run and keep the output for the verdict
"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== src/soc_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_defs.svh"

// Memory-mapped I/O block: register file plus UART transmitter
module soc_io_top
  import soc_io_pkg::*;
#(
  parameter int CLOCK_FREQ = `SOC_IO_CLOCK_FREQ,
  parameter int BAUD_RATE  = `SOC_IO_BAUD_RATE
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire io_wr_req_t            wr_req,
  input  wire io_rd_req_t            rd_req,
  output logic [`SOC_IO_DATA_W-1:0]  rdata,
  output logic                       led,
  output logic [7:0]                 gpio,
  output logic                       uart_txd
);

  // Register file to transmitter
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_ready;

  io_reg_file io_reg_file_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .tx_ready (tx_ready),
    .rdata    (rdata),
    .led      (led),
    .gpio     (gpio),
    .tx_start (tx_start),
    .tx_byte  (tx_byte)
  );

  uart_tx #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE)
  ) uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .txd      (uart_txd)
  );

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_defs.svh"

// UART transmitter, 8N1, LSB first, line idles high
// The caller only pulses tx_start while tx_ready is high
module uart_tx #(
  parameter int CLOCK_FREQ = `SOC_IO_CLOCK_FREQ,
  parameter int BAUD_RATE  = `SOC_IO_BAUD_RATE
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx_start,
  input  wire  [7:0] tx_byte,
  output logic       tx_ready,
  output logic       txd
);

  // Clock cycles per bit on the line
  localparam int CYCLES_PER_BIT = CLOCK_FREQ / BAUD_RATE;
  localparam int CNT_W          = $clog2(CYCLES_PER_BIT + 1);

  // Start bit, eight data bits and a stop bit
  localparam int FRAME_BITS     = 10;

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_BIT - 1);
  localparam logic [3:0]       BIT_LAST = 4'(FRAME_BITS - 1);

  logic [CNT_W-1:0]      baud_cnt;
  logic [3:0]            bit_idx;

  // Bit 0 is on the line, ones shift in from the top
  logic [FRAME_BITS-1:0] frame;

  logic                  bit_end;

  assign bit_end = !tx_ready && (baud_cnt == CNT_LAST);
  assign txd     = frame[0];

  // Bit period counter, runs only during a frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (tx_start || bit_end) begin
      baud_cnt <= '0;
    end else if (!tx_ready) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Index of the bit now on the line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_idx <= '0;
    end else if (tx_start) begin
      bit_idx <= '0;
    end else if (bit_end && bit_idx != BIT_LAST) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  // Frame shift register
  // After the stop bit only ones remain, so the line returns to idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame <= '1;
    end else if (tx_start) begin
      frame <= {1'b1, tx_byte, 1'b0};
    end else if (bit_end) begin
      frame <= {1'b1, frame[FRAME_BITS-1:1]};
    end
  end

  // Busy from the start edge until the stop bit has run its full period
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_ready <= 1'b1;
    end else if (tx_start) begin
      tx_ready <= 1'b0;
    end else if (bit_end && bit_idx == BIT_LAST) begin
      tx_ready <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verification/soc_io_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// Concurrent checks on the I/O block, attached to soc_io_top
module soc_io_chk
  import soc_io_pkg::*;
(
  input wire              clk,
  input wire              rst_n,
  input wire io_wr_req_t  wr_req,
  input wire io_rd_req_t  rd_req,
  input wire [31:0]       rdata,
  input wire [7:0]        gpio,
  input wire              uart_txd,
  input wire              tx_ready
);

  logic [7:0] rd_off;
  logic       gpio_wr;
  logic       rd_unmapped;

  assign gpio_wr = wr_req.wen && wr_req.strb[0] && (wr_req.addr[7:0] == 8'h0C);
  assign rd_off  = rd_req.addr[7:0];

  // Offsets outside the register map
  assign rd_unmapped = rd_req.ren && (rd_off != 8'h00) && (rd_off != 8'h04) &&
                       (rd_off != 8'h08) && (rd_off != 8'h0C);

  // Idle line whenever the transmitter is free
  idle_line_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    tx_ready |-> uart_txd)
    else $error("uart_txd low while the transmitter reports ready");

  gpio_only_on_write: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(gpio) |-> $past(gpio_wr))
    else $error("gpio changed without a strobed write to offset 0x0C");

  unmapped_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
    rd_unmapped |=> (rdata == 32'h0))
    else $error("read of an unmapped offset returned nonzero data");

endmodule

bind soc_io_top soc_io_chk soc_io_chk_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .wr_req   (wr_req),
  .rd_req   (rd_req),
  .rdata    (rdata),
  .gpio     (gpio),
  .uart_txd (uart_txd),
  .tx_ready (tx_ready)
);

`default_nettype wire

// ==== verification/soc_io_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the memory-mapped I/O block
module soc_io_tb
  import soc_io_pkg::*;
();

  // 10 clock cycles per UART bit
  localparam int CLOCK_FREQ = 1000000;
  localparam int BAUD_RATE  = 100000;
  localparam int BIT_CYCLES = CLOCK_FREQ / BAUD_RATE;

  // Tests need about 700 cycles
  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  io_wr_req_t  wr_req;
  io_rd_req_t  rd_req;
  logic [31:0] rdata;
  logic        led;
  logic [7:0]  gpio;
  logic        uart_txd;

  string       test_name;
  int          cycle_count = 0;
  logic [31:0] lfsr_state;

  soc_io_top #(
    .CLOCK_FREQ (CLOCK_FREQ),
    .BAUD_RATE  (BAUD_RATE)
  ) soc_io_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .rdata    (rdata),
    .led      (led),
    .gpio     (gpio),
    .uart_txd (uart_txd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: %s expected 0x%08h actual 0x%08h",
               test_name, what, expected, actual);
      stop_on_failure();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_byte(output logic [7:0] value);
    int i;
    value = '0;
    for (i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
  endtask

  // Called just after a rising edge, the write is sampled on the next one
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    io_wr_req_t req;
    req.wen  = 1'b1;
    req.addr = addr;
    req.data = data;
    req.strb = strb;
    wr_req <= req;
    @(posedge clk);
    wr_req <= '0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] value);
    io_rd_req_t req;
    req.ren  = 1'b1;
    req.addr = addr;
    rd_req <= req;
    @(posedge clk);
    rd_req <= '0;
    @(negedge clk);
    value = rdata;
    @(posedge clk);
  endtask

  // Reads GPIO first so that a stale zero cannot pass
  task automatic expect_zero_read(input logic [31:0] addr);
    logic [31:0] value;
    read_reg(32'h0000_000C, value);
    read_reg(addr, value);
    check_equal("unmapped read", 32'h0, value);
  endtask

  // Finds the start bit, then samples each bit at its centre
  task automatic capture_frame(output logic [9:0] bits);
    int waited;
    int i;
    waited = 0;
    bits = '1;
    @(negedge clk);
    while (uart_txd !== 1'b0) begin
      waited++;
      if (waited > 4 * BIT_CYCLES) begin
        $display("No start bit appeared on uart_txd after the transmit write");
        stop_on_failure();
      end
      @(negedge clk);
    end
    repeat (BIT_CYCLES / 2) @(negedge clk);
    bits[0] = uart_txd;
    for (i = 1; i < 10; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      bits[i] = uart_txd;
    end
  endtask

  // Line must stay idle while the stop bit finishes
  task automatic wait_tx_ready();
    logic [31:0] status;
    int polls;
    polls = 0;
    status = '0;
    while (status[0] !== 1'b1) begin
      if (polls > 20) begin
        $display("Transmitter never returned to ready after the frame");
        stop_on_failure();
      end
      read_reg(32'h0000_0004, status);
      @(negedge clk);
      check_equal("line idle after frame", 32'h1, 32'(uart_txd));
      @(posedge clk);
      polls++;
    end
    check_equal("status after frame", 32'h1, status);
  endtask

  task automatic check_frame(input logic [9:0] bits, input logic [7:0] data);
    check_equal("start bit", 32'h0, 32'(bits[0]));
    check_equal("data bits", 32'(data), 32'(bits[8:1]));
    check_equal("stop bit", 32'h1, 32'(bits[9]));
  endtask

  task automatic reset_values();
    logic [31:0] value;
    test_name = "reset";
    @(negedge clk);
    check_equal("led", 32'h0, 32'(led));
    check_equal("gpio", 32'h0, 32'(gpio));
    check_equal("uart_txd", 32'h1, 32'(uart_txd));
    check_equal("rdata", 32'h0, rdata);
    @(posedge clk);
    read_reg(32'h0000_0004, value);
    check_equal("status ready", 32'h1, value);
  endtask

  task automatic led_gpio_access();
    logic [31:0] value;
    logic [7:0]  data;
    int          i;
    test_name = "led_gpio";
    write_reg(32'h0000_0008, 32'h1, 4'h1);
    @(negedge clk);
    check_equal("led after write 1", 32'h1, 32'(led));
    @(posedge clk);
    read_reg(32'h0000_0008, value);
    check_equal("led readback 1", 32'h1, value);
    write_reg(32'h0000_0008, 32'h0, 4'h1);
    @(negedge clk);
    check_equal("led after write 0", 32'h0, 32'(led));
    @(posedge clk);
    read_reg(32'h0000_0008, value);
    check_equal("led readback 0", 32'h0, value);
    for (i = 0; i < 4; i++) begin
      random_byte(data);
      write_reg(32'h0000_000C, 32'(data), 4'h1);
      @(negedge clk);
      check_equal("gpio after write", 32'(data), 32'(gpio));
      @(posedge clk);
      read_reg(32'h0000_000C, value);
      check_equal("gpio readback", 32'(data), value);
    end
    // Back-to-back writes, LED then GPIO
    random_byte(data);
    wr_req <= '{wen: 1'b1, addr: 32'h0000_0008, data: 32'h1, strb: 4'h1};
    @(posedge clk);
    wr_req <= '{wen: 1'b1, addr: 32'h0000_000C, data: 32'(data), strb: 4'h1};
    @(negedge clk);
    check_equal("led in back-to-back", 32'h1, 32'(led));
    @(posedge clk);
    wr_req <= '0;
    @(negedge clk);
    check_equal("gpio in back-to-back", 32'(data), 32'(gpio));
    check_equal("led held", 32'h1, 32'(led));
    // Back-to-back reads
    @(posedge clk);
    rd_req <= '{ren: 1'b1, addr: 32'h0000_0008};
    @(posedge clk);
    rd_req <= '{ren: 1'b1, addr: 32'h0000_000C};
    @(negedge clk);
    check_equal("led back-to-back read", 32'h1, rdata);
    @(posedge clk);
    rd_req <= '0;
    @(negedge clk);
    check_equal("gpio back-to-back read", 32'(data), rdata);
    repeat (3) @(negedge clk);
    check_equal("rdata held", 32'(data), rdata);
    @(posedge clk);
  endtask

  task automatic decode_and_strobes();
    logic [31:0] value;
    logic [7:0]  data;
    test_name = "decode";
    random_byte(data);
    data = data | 8'h01;
    write_reg(32'hDEAD_BE0C, 32'(data), 4'h1);
    @(negedge clk);
    check_equal("gpio via upper bits", 32'(data), 32'(gpio));
    @(posedge clk);
    read_reg(32'h1234_560C, value);
    check_equal("gpio read via upper bits", 32'(data), value);
    // LED is 1 here, so clearing it shows the upper-bit address hit
    write_reg(32'hFFFF_FF08, 32'h0, 4'h1);
    // None of these may change a register
    write_reg(32'h0000_0010, 32'hFFFF_FFFF, 4'hF);
    write_reg(32'h0000_0014, 32'hFFFF_FFFF, 4'hF);
    write_reg(32'h0000_000C, 32'(~data), 4'hE);
    write_reg(32'h0000_0008, 32'h1, 4'h0);
    @(negedge clk);
    check_equal("led unchanged", 32'h0, 32'(led));
    check_equal("gpio unchanged", 32'(data), 32'(gpio));
    @(posedge clk);
    expect_zero_read(32'h0000_0010);
    expect_zero_read(32'h0000_0014);
    expect_zero_read(32'h0000_00FC);
    expect_zero_read(32'hABCD_EF20);
    expect_zero_read(32'h0000_0000);
  endtask

  task automatic uart_frame();
    logic [31:0] status;
    logic [9:0]  bits;
    test_name = "uart_frame";
    fork
      capture_frame(bits);
      begin
        write_reg(32'h0000_0000, 32'h41, 4'h1);
        @(posedge clk);
        read_reg(32'h0000_0004, status);
        check_equal("status busy", 32'h0, status);
      end
    join
    @(posedge clk);
    check_frame(bits, 8'h41);
    wait_tx_ready();
  endtask

  task automatic busy_write_drop();
    logic [31:0] status;
    logic [9:0]  bits;
    test_name = "busy_drop";
    fork
      capture_frame(bits);
      begin
        write_reg(32'h0000_0000, 32'hC6, 4'h1);
        @(posedge clk);
        read_reg(32'h0000_0004, status);
        check_equal("status busy", 32'h0, status);
        write_reg(32'h0000_0000, 32'h39, 4'h1);
        read_reg(32'h0000_0004, status);
        check_equal("status still busy", 32'h0, status);
      end
    join
    @(posedge clk);
    check_frame(bits, 8'hC6);
    wait_tx_ready();
    // A dropped byte must never start a frame of its own
    repeat (2 * BIT_CYCLES) begin
      @(negedge clk);
      check_equal("no second frame", 32'h1, 32'(uart_txd));
    end
    @(posedge clk);
  endtask

  initial begin
    rst_n       = 1'b0;
    wr_req      = '0;
    rd_req      = '0;
    lfsr_state  = 32'h95fb;
    test_name   = "init";
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_values();
    led_gpio_access();
    decode_and_strobes();
    uart_frame();
    busy_write_drop();
    repeat (2) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
